//--- design/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// Operand and result width of the divide unit.
`define DIV_XLEN 64

// Number of restoring steps.
// There is one quotient bit per step.
`define DIV_STEPS `DIV_XLEN

// Width of the W-suffixed word operations.
`define DIV_WLEN 32

`endif

//--- design/div_pkg.sv
`include "div_defs.svh"

package div_pkg;

    typedef logic [`DIV_XLEN-1:0] xlen_t;  // Operands, quotient and remainder.

    // Counts completed core steps, up to and including DIV_STEPS.
    typedef logic [$clog2(`DIV_STEPS+1)-1:0] step_cnt_t;

    // Request as issued by the execute stage.
    typedef struct packed {
        logic  op_signed;   // DIV, REM, DIVW, REMW.
        logic  op_rem;      // Return the remainder instead of the quotient.
        logic  op_word;     // 32-bit operation with a sign-extended result.
        xlen_t dividend;
        xlen_t divisor;
    } div_req_t;

    // Unsigned operands plus everything the fix stage needs afterwards.
    typedef struct packed {
        xlen_t abs_dividend;
        xlen_t abs_divisor;
        logic  neg_quot;       // Quotient must be negated.
        logic  neg_rem;        // Remainder must be negated.
        logic  div_zero;
        logic  overflow;       // Most negative value divided by minus one.
        logic  op_rem;
        logic  op_word;
        xlen_t orig_dividend;  // Dividend after word extension.
    } div_prep_t;

    // Unsigned core output.
    typedef struct packed {
        xlen_t quotient;
        xlen_t remainder;
    } div_raw_t;

endpackage

//--- design/div_operand_prep.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_operand_prep (
    input  logic               clk,
    input  logic               rst,
    input  logic               prep_load,
    input  div_pkg::div_req_t  req_data,
    output div_pkg::div_prep_t prep
);
    import div_pkg::*;

    localparam int EXT_W = `DIV_XLEN - `DIV_WLEN;

    xlen_t     ext_dividend;
    xlen_t     ext_divisor;
    xlen_t     min_val;
    logic      neg_a;
    logic      neg_b;
    div_prep_t prep_next;

    always_comb begin
        // Word forms only look at the low half of each operand.
        if (req_data.op_word) begin
            if (req_data.op_signed) begin
                ext_dividend = {{EXT_W{req_data.dividend[`DIV_WLEN-1]}},
                                req_data.dividend[`DIV_WLEN-1:0]};
                ext_divisor  = {{EXT_W{req_data.divisor[`DIV_WLEN-1]}},
                                req_data.divisor[`DIV_WLEN-1:0]};
            end else begin
                ext_dividend = {{EXT_W{1'b0}}, req_data.dividend[`DIV_WLEN-1:0]};
                ext_divisor  = {{EXT_W{1'b0}}, req_data.divisor[`DIV_WLEN-1:0]};
            end
            min_val = {{(EXT_W+1){1'b1}}, {(`DIV_WLEN-1){1'b0}}};
        end else begin
            ext_dividend = req_data.dividend;
            ext_divisor  = req_data.divisor;
            min_val      = {1'b1, {(`DIV_XLEN-1){1'b0}}};
        end

        // After extension bit 63 carries the sign in both widths.
        neg_a = req_data.op_signed & ext_dividend[`DIV_XLEN-1];
        neg_b = req_data.op_signed & ext_divisor[`DIV_XLEN-1];

        prep_next.abs_dividend  = neg_a ? (~ext_dividend + 1'b1) : ext_dividend;
        prep_next.abs_divisor   = neg_b ? (~ext_divisor + 1'b1) : ext_divisor;
        prep_next.neg_quot      = neg_a ^ neg_b;
        prep_next.neg_rem       = neg_a;  // Remainder follows the dividend.
        prep_next.div_zero      = (ext_divisor == '0);
        prep_next.overflow      = req_data.op_signed && (ext_divisor == '1) &&
                                  (ext_dividend == min_val);
        prep_next.op_rem        = req_data.op_rem;
        prep_next.op_word       = req_data.op_word;
        prep_next.orig_dividend = ext_dividend;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prep <= '0;
        end else if (prep_load) begin
            prep <= prep_next;
        end
    end

    // The controller accepts at most one request per handshake.
    a_load_pulse: assert property (@(posedge clk) disable iff (rst)
        prep_load |=> !prep_load);

endmodule

//--- design/div_iter_core.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_iter_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               core_start,
    input  div_pkg::div_prep_t prep,
    output logic               core_done,
    output div_pkg::div_raw_t  raw
);
    import div_pkg::*;

    localparam int ACC_W = 2 * `DIV_XLEN;

    // Upper half holds the partial remainder, lower half collects quotient bits.
    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_cur;
    logic [ACC_W-1:0] acc_shift;
    logic [ACC_W-1:0] div_wide;
    logic [ACC_W-1:0] acc_step;
    xlen_t            divisor_q;
    xlen_t            div_cur;
    step_cnt_t        cnt;
    step_cnt_t        cnt_next;
    logic             busy;
    logic             step_en;

    always_comb begin
        // The start cycle already performs the first step on the fresh operands.
        acc_cur   = core_start ? {{`DIV_XLEN{1'b0}}, prep.abs_dividend} : acc;
        div_cur   = core_start ? prep.abs_divisor : divisor_q;
        acc_shift = acc_cur << 1;
        div_wide  = {div_cur, {`DIV_XLEN{1'b0}}};
        if (acc_shift >= div_wide) begin
            acc_step = acc_shift - div_wide + ACC_W'(1);  // Subtract and set the bit.
        end else begin
            acc_step = acc_shift;
        end
        cnt_next = cnt + 1'b1;
        step_en  = (core_start || busy) && !flush;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy      <= 1'b0;
            cnt       <= '0;
            core_done <= 1'b0;
        end else begin
            core_done <= 1'b0;
            if (step_en) begin
                if (cnt_next == step_cnt_t'(`DIV_STEPS)) begin
                    busy      <= 1'b0;
                    cnt       <= '0;
                    core_done <= 1'b1;  // Last step just finished.
                end else begin
                    busy <= 1'b1;
                    cnt  <= cnt_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (core_start) begin
            divisor_q <= prep.abs_divisor;
        end
        if (step_en) begin
            acc <= acc_step;
        end
    end

    // The accumulator stays put once the core is idle, so raw is stable after done.
    always_comb begin
        raw.quotient  = acc[`DIV_XLEN-1:0];
        raw.remainder = acc[ACC_W-1:`DIV_XLEN];
    end

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        core_start |-> !busy);

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        core_done |=> !core_done);

endmodule

//--- design/div_result_fix.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_result_fix (
    input  logic               clk,
    input  logic               rst,
    input  logic               fix_load,
    input  div_pkg::div_prep_t prep,
    input  div_pkg::div_raw_t  raw,
    output div_pkg::xlen_t     result
);
    import div_pkg::*;

    localparam int EXT_W = `DIV_XLEN - `DIV_WLEN;

    xlen_t fix_quot;
    xlen_t fix_rem;
    xlen_t sel;
    xlen_t result_next;

    always_comb begin
        // Two's-complement negation restores the signs lost in prep.
        fix_quot = prep.neg_quot ? (~raw.quotient + 1'b1) : raw.quotient;
        fix_rem  = prep.neg_rem ? (~raw.remainder + 1'b1) : raw.remainder;

        if (prep.div_zero) begin
            fix_quot = '1;
            fix_rem  = prep.orig_dividend;
        end else if (prep.overflow) begin
            fix_quot = prep.orig_dividend;  // Quotient wraps to the dividend.
            fix_rem  = '0;
        end

        sel = prep.op_rem ? fix_rem : fix_quot;

        // Word results are always sign-extended from bit 31.
        if (prep.op_word) begin
            result_next = {{EXT_W{sel[`DIV_WLEN-1]}}, sel[`DIV_WLEN-1:0]};
        end else begin
            result_next = sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (fix_load) begin
            result <= result_next;
        end
    end

endmodule

//--- design/div_req_ctrl.sv
`timescale 1ns/1ps

module div_req_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic flush,
    input  logic core_done,
    output logic ack,
    output logic prep_load,
    output logic core_start,
    output logic fix_load
);

    typedef enum logic [2:0] {
        IDLE,
        PREP,
        RUN,
        FIX,
        DONE,
        WAIT_LOW
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (req) state_next = PREP;
            PREP:     state_next = RUN;
            RUN:      if (core_done) state_next = FIX;
            FIX:      state_next = DONE;
            DONE:     if (!req) state_next = IDLE;       // Requester closed the handshake.
            WAIT_LOW: if (!req) state_next = IDLE;
            default:  state_next = IDLE;
        endcase

        // A flushed operation must see req low before the next accept.
        if (flush) begin
            state_next = WAIT_LOW;
        end
    end

    // Sequencing pulses line up with the datapath register edges.
    assign prep_load  = (state == IDLE) && req && !flush;
    assign core_start = (state == PREP) && !flush;
    assign fix_load   = (state == RUN) && core_done && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            ack   <= (state_next == DONE);  // High for exactly the DONE residency.
        end
    end

    // Req must still be high on the edge that raises ack.
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req));

    // Only a dropped req or a flush may end the handshake.
    a_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> $past(!req || flush));

endmodule

//--- design/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  logic              flush,
    input  div_pkg::div_req_t req_data,
    output logic              ack,
    output div_pkg::xlen_t    result
);
    import div_pkg::*;

    logic      prep_load;
    logic      core_start;
    logic      core_done;
    logic      fix_load;
    div_prep_t prep;
    div_raw_t  raw;

    // Handshake and sequencing.
    div_req_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .flush      (flush),
        .core_done  (core_done),
        .ack        (ack),
        .prep_load  (prep_load),
        .core_start (core_start),
        .fix_load   (fix_load)
    );

    div_operand_prep prep_i (
        .clk       (clk),
        .rst       (rst),
        .prep_load (prep_load),
        .req_data  (req_data),
        .prep      (prep)
    );

    div_iter_core core_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .core_start (core_start),
        .prep       (prep),
        .core_done  (core_done),
        .raw        (raw)
    );

    // Sign and special-case correction, then word extension.
    div_result_fix fix_i (
        .clk      (clk),
        .rst      (rst),
        .fix_load (fix_load),
        .prep     (prep),
        .raw      (raw),
        .result   (result)
    );

endmodule

//--- verif/div_ref_model.svh
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// RISC-V M-extension divide results, computed with the simulator's own arithmetic.
// Signed division in SystemVerilog truncates toward zero, as RISC-V does.

function automatic logic [63:0] model_div64(input logic sgn, input logic rem,
                                            input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = a;
    sb = b;
    if (b == 64'd0) begin
        return rem ? a : {64{1'b1}};  // Division by zero.
    end
    if (sgn && a == {1'b1, 63'd0} && b == {64{1'b1}}) begin
        return rem ? 64'd0 : a;
    end
    if (sgn) begin
        return rem ? sa % sb : sa / sb;
    end
    return rem ? a % b : a / b;
endfunction

function automatic logic [31:0] model_div32(input logic sgn, input logic rem,
                                            input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    if (b == 32'd0) begin
        return rem ? a : {32{1'b1}};
    end
    if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        return rem ? 32'd0 : a;  // Signed overflow in the word width.
    end
    if (sgn) begin
        return rem ? sa % sb : sa / sb;
    end
    return rem ? a % b : a / b;
endfunction

// Word forms ignore the upper operand halves and sign-extend the 32-bit result.
function automatic xlen_t model_result(input div_req_t r);
    logic [31:0] w;
    if (r.op_word) begin
        w = model_div32(r.op_signed, r.op_rem, r.dividend[31:0], r.divisor[31:0]);
        return {{32{w[31]}}, w};
    end
    return model_div64(r.op_signed, r.op_rem, r.dividend, r.divisor);
endfunction

`endif

//--- verif/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;
    import div_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_UNSIGNED = 40;
    localparam int N_SIGNED = 40;
    localparam int N_WORD = 40;
    localparam int N_SPECIAL = 12;
    localparam int N_TIMING = 4;
    localparam int N_FLUSH = 6;
    // A flush case costs the aborted run, the quiet window and one normal operation.
    localparam int TOTAL_OPS = N_UNSIGNED + N_SIGNED + N_WORD + N_SPECIAL + N_TIMING
                               + 3 * N_FLUSH;
    localparam int OP_CYCLES = 80;
    localparam int LATENCY = 66;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * OP_CYCLES + RESET_CYCLES;
    localparam logic [31:0] SEED = 32'ha003_a64f;

    logic     clk;
    logic     rst;
    logic     req;
    logic     flush;
    div_req_t req_data;
    logic     ack;
    xlen_t    result;

    logic [31:0] lfsr_state;
    string       cur_test;
    int          num_tests;
    int          num_checks;
    int          num_errors;
    int          test_err_base;

    `include "div_ref_model.svh"

    div_unit dut_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .flush    (flush),
        .req_data (req_data),
        .ack      (ack),
        .result   (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2 and 1 give a maximal-length sequence.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Random shifts spread the magnitudes; signed operands are negative three times in four.
    function automatic xlen_t rand_operand(input logic sgn, input logic word);
        xlen_t       v;
        logic [31:0] low;
        if (word) begin
            low = 32'(rand_bits(32) >> rand_bits(5));
            if (sgn && rand_bits(2) != 0) low = -low;
            v = {32'(rand_bits(32)), low};  // Upper half is garbage.
        end else begin
            v = rand_bits(64) >> rand_bits(6);
            if (sgn && rand_bits(2) != 0) v = -v;
        end
        return v;
    endfunction

    function automatic div_req_t rand_req(input logic sgn, input logic word);
        div_req_t r;
        r.op_signed = sgn;
        r.op_word   = word;
        r.op_rem    = (rand_bits(1) != 0);
        r.dividend  = rand_operand(sgn, word);
        r.divisor   = rand_operand(sgn, word);
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = num_errors;
    endtask

    task automatic end_test();
        num_tests++;
        $display("Test %s finished with %0d errors", cur_test, num_errors - test_err_base);
    endtask

    // One full four-phase operation, entered and left on a falling edge.
    task automatic run_op(input div_req_t r, input int hold);
        int cycles;
        req_data = r;
        req      = 1'b1;
        @(posedge clk);  // The accepting edge.
        cycles = 0;
        @(negedge clk);
        while (!ack && cycles < OP_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            num_errors++;
            $display("%s: no ack within %0d cycles of the request", cur_test, OP_CYCLES);
            req = 1'b0;
            @(negedge clk);
            return;
        end
        check({cur_test, " latency"}, 64'(LATENCY), 64'(cycles));
        check({cur_test, " result"}, model_result(r), result);
        repeat (hold) begin
            @(negedge clk);
            check({cur_test, " ack held"}, 64'd1, 64'(ack));
        end
        req = 1'b0;
        @(negedge clk);
        check({cur_test, " ack fall"}, 64'd0, 64'(ack));
    endtask

    task automatic test_special();
        div_req_t r;
        for (int i = 0; i < 8; i++) begin
            r.op_signed = i[0];
            r.op_rem    = i[1];
            r.op_word   = i[2];
            r.dividend  = rand_bits(64);
            r.divisor   = i[2] ? {32'(rand_bits(32)), 32'd0} : 64'd0;
            run_op(r, 0);
        end
        for (int j = 0; j < 4; j++) begin
            r.op_signed = 1'b1;
            r.op_rem    = j[0];
            r.op_word   = j[1];
            r.dividend  = j[1] ? {32'(rand_bits(32)), 32'h8000_0000} : {1'b1, 63'd0};
            r.divisor   = j[1] ? {32'(rand_bits(32)), 32'hffff_ffff} : {64{1'b1}};
            run_op(r, 0);
        end
    endtask

    task automatic test_flush();
        int   delay;
        logic seen;
        for (int i = 0; i < N_FLUSH; i++) begin
            req_data = rand_req(rand_bits(1) != 0, rand_bits(1) != 0);
            delay    = int'(rand_bits(7)) % LATENCY;  // Flush lands before ack can rise.
            req      = 1'b1;
            repeat (delay) @(negedge clk);
            flush = 1'b1;
            seen  = 1'b0;
            for (int k = 0; k < OP_CYCLES; k++) begin
                @(negedge clk);
                flush = 1'b0;
                if (ack) seen = 1'b1;
            end
            check({cur_test, " no ack after flush"}, 64'd0, 64'(seen));
            req = 1'b0;
            @(negedge clk);
            run_op(rand_req(rand_bits(1) != 0, rand_bits(1) != 0), 0);
        end
    endtask

    initial begin
        lfsr_state = SEED;
        clk        = 1'b0;
        rst        = 1'b1;
        req        = 1'b0;
        flush      = 1'b0;
        req_data   = '0;
        num_tests  = 0;
        num_checks = 0;
        num_errors = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        begin_test("divu_remu");
        repeat (N_UNSIGNED) run_op(rand_req(1'b0, 1'b0), int'(rand_bits(2)));
        end_test();

        begin_test("div_rem");
        repeat (N_SIGNED) run_op(rand_req(1'b1, 1'b0), int'(rand_bits(2)));
        end_test();

        begin_test("word_ops");
        repeat (N_WORD) run_op(rand_req(rand_bits(1) != 0, 1'b1), int'(rand_bits(2)));
        end_test();

        begin_test("special");
        test_special();
        end_test();

        // Longer holds keep the unit in DONE for several cycles.
        begin_test("handshake");
        repeat (N_TIMING) begin
            run_op(rand_req(rand_bits(1) != 0, rand_bits(1) != 0), 4 + int'(rand_bits(3)));
        end
        end_test();

        begin_test("flush");
        test_flush();
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, num_checks,
                 num_errors);
        if (num_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- div_unit.f
+incdir+design
+incdir+verif
design/div_pkg.sv
design/div_operand_prep.sv
design/div_iter_core.sv
design/div_result_fix.sv
design/div_req_ctrl.sv
design/div_unit.sv
verif/div_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the divide unit testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=div_unit_sim
LOG_FILE=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert -Wno-fatal \
    -f div_unit.f --top-module div_unit_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG_FILE"; then
    echo "Simulation reported errors, see $LOG_FILE"
    exit 1
fi

echo "Simulation finished without errors"
exit 0
